//--- sdf_pkg.sv
package sdf_pkg;

  // fixed point format, signed 8.8
  localparam int FP_W    = 16;
  localparam int FP_FRAC = 8;
  localparam int VEC_W   = 3 * FP_W;

  typedef logic signed [FP_W-1:0] fp;
  // x in the top third, z in the bottom
  typedef logic [VEC_W-1:0] vec3;
  typedef logic [5:0] step_t;

  typedef enum logic [1:0] {
    scene_cube,
    scene_cube_inf,
    scene_sponge_inf
  } scene_t;

  typedef enum logic [1:0] {
    idle,
    issue,
    wait_sdf,
    update
  } march_state_t;

  localparam fp FP_ONE           = 16'sd256;
  localparam fp FP_HALF          = 16'sd128;
  localparam fp FP_QUARTER       = 16'sd64;
  localparam fp FP_ONE_SIXTEENTH = 16'sd16;

  // sponge hole offsets, rounded to nearest lsb
  localparam fp FP_MAGIC_A = -16'sd115;
  localparam fp FP_MAGIC_B = -16'sd73;
  localparam fp FP_MAGIC_C = -16'sd47;
  localparam fp FP_MAGIC_D = -16'sd13;

  // query pipeline depth, point to sdf
  localparam int SDF_LATENCY = 4;
  // 1/64
  localparam fp EPSILON = 16'sd4;
  // 16.0
  localparam fp FAR_LIMIT = 16'sd4096;
  localparam step_t MAX_STEPS = 6'd48;

  // scalar arithmetic, all wrapping
  function automatic fp fp_add(fp a, fp b);
    return a + b;
  endfunction

  function automatic fp fp_sub(fp a, fp b);
    return a - b;
  endfunction

  function automatic fp fp_mul(fp a, fp b);
    logic signed [2*FP_W-1:0] prod;
    prod = a * b;
    // drop the extra fraction bits, no rounding
    return prod[FP_FRAC +: FP_W];
  endfunction

  function automatic fp fp_min(fp a, fp b);
    return (a < b) ? a : b;
  endfunction

  function automatic fp fp_max(fp a, fp b);
    return (a > b) ? a : b;
  endfunction

  function automatic fp fp_abs(fp a);
    return a[FP_W-1] ? -a : a;
  endfunction

  // low fraction bits, same as x - floor(x)
  function automatic fp fract(fp a);
    return fp'({{(FP_W-FP_FRAC){1'b0}}, a[FP_FRAC-1:0]});
  endfunction

  // vector access
  function automatic fp vec3_x(vec3 v);
    return v[3*FP_W-1 -: FP_W];
  endfunction

  function automatic fp vec3_y(vec3 v);
    return v[2*FP_W-1 -: FP_W];
  endfunction

  function automatic fp vec3_z(vec3 v);
    return v[FP_W-1:0];
  endfunction

  function automatic vec3 make_vec3(fp x, fp y, fp z);
    return {x, y, z};
  endfunction

  // componentwise ops
  function automatic vec3 vec3_add(vec3 a, vec3 b);
    return make_vec3(fp_add(vec3_x(a), vec3_x(b)), fp_add(vec3_y(a), vec3_y(b)),
                     fp_add(vec3_z(a), vec3_z(b)));
  endfunction

  function automatic vec3 vec3_sub(vec3 a, vec3 b);
    return make_vec3(fp_sub(vec3_x(a), vec3_x(b)), fp_sub(vec3_y(a), vec3_y(b)),
                     fp_sub(vec3_z(a), vec3_z(b)));
  endfunction

  function automatic vec3 vec3_abs(vec3 v);
    return make_vec3(fp_abs(vec3_x(v)), fp_abs(vec3_y(v)), fp_abs(vec3_z(v)));
  endfunction

  function automatic vec3 vec3_fract(vec3 v);
    return make_vec3(fract(vec3_x(v)), fract(vec3_y(v)), fract(vec3_z(v)));
  endfunction

  // multiply by 2^n
  function automatic vec3 vec3_sl(vec3 v, int unsigned n);
    return make_vec3(vec3_x(v) <<< n, vec3_y(v) <<< n, vec3_z(v) <<< n);
  endfunction

  // divide by 2^n, sign kept
  function automatic vec3 vec3_sr(vec3 v, int unsigned n);
    return make_vec3(vec3_x(v) >>> n, vec3_y(v) >>> n, vec3_z(v) >>> n);
  endfunction

  function automatic vec3 vec3_scaled(vec3 v, fp s);
    return make_vec3(fp_mul(vec3_x(v), s), fp_mul(vec3_y(v), s), fp_mul(vec3_z(v), s));
  endfunction

  // box bound, Chebyshev style, exact only outside along an axis
  function automatic fp sd_box_fast(vec3 p, fp half);
    vec3 a;
    a = vec3_abs(p);
    return fp_sub(fp_max(fp_max(vec3_x(a), vec3_y(a)), vec3_z(a)), half);
  endfunction

  // second largest component, cross shape for the sponge holes
  function automatic fp cross_max_min(vec3 p);
    return fp_min(fp_max(vec3_x(p), vec3_y(p)),
                  fp_min(fp_max(vec3_y(p), vec3_z(p)), fp_max(vec3_x(p), vec3_z(p))));
  endfunction

endpackage

//--- sdf_query_if.sv
interface sdf_query_if import sdf_pkg::*; ();

  // request side
  vec3    point;
  scene_t scene;
  logic   query_valid;

  // answer, SDF_LATENCY cycles after the request
  fp      sdf;
  logic   sdf_valid;

  modport marcher (
    output point, scene, query_valid,
    input  sdf, sdf_valid
  );

  modport evaluator (
    input  point, scene, query_valid,
    output sdf, sdf_valid
  );

endinterface

//--- sdf_query_sponge_inf.sv
module sdf_query_sponge_inf import sdf_pkg::*; (
  input  logic clk_in,
  input  vec3  point,
  output fp    sdf
);

  // folded cell coordinates per layer
  vec3 p1;
  vec3 p2;
  vec3 p3;
  vec3 p4;
  // layer distances before the running max
  fp   l1;
  fp   l2;
  fp   l3;
  fp   l4;
  // running max registers
  fp   d1;
  fp   d2;
  fp   d3;

  // layer one, cells of size 2
  assign p1 = vec3_abs(vec3_sub(vec3_sl(vec3_fract(vec3_sr(point, 1)), 1),
                                make_vec3(FP_ONE, FP_ONE, FP_ONE)));
  // layer two, unit cells
  assign p2 = vec3_abs(vec3_sub(vec3_fract(point),
                                make_vec3(FP_HALF, FP_HALF, FP_HALF)));
  // layer three, half size cells
  assign p3 = vec3_abs(vec3_sub(vec3_sr(vec3_fract(vec3_sl(point, 1)), 1),
                                make_vec3(FP_QUARTER, FP_QUARTER, FP_QUARTER)));
  // layer four, fine holes at 1/8
  assign p4 = vec3_abs(vec3_sub(vec3_sr(vec3_fract(vec3_sl(point, 3)), 3),
                                make_vec3(FP_ONE_SIXTEENTH, FP_ONE_SIXTEENTH,
                                          FP_ONE_SIXTEENTH)));

  assign l1 = fp_add(cross_max_min(p1), FP_MAGIC_A);
  assign l2 = fp_add(cross_max_min(p2), FP_MAGIC_B);
  assign l3 = fp_add(cross_max_min(p3), FP_MAGIC_C);
  assign l4 = fp_add(cross_max_min(p4), FP_MAGIC_D);

  // one layer per stage, each stage reads the current point
  // so the point must stay put for four cycles
  always_ff @(posedge clk_in) begin
    d1  <= l1;
    d2  <= fp_max(d1, l2);
    d3  <= fp_max(d2, l3);
    sdf <= fp_max(d3, l4);
  end

  // last layer alone bounds the output from below
  a_sdf_floor: assert property (@(posedge clk_in)
    !$isunknown(sdf) |-> (sdf >= FP_MAGIC_D))
    else $error("sponge sdf %0d below hole floor", sdf);

endmodule

//--- sdf_scene_eval.sv
module sdf_scene_eval import sdf_pkg::*; (
  input logic     clk_in,
  input logic     arst_n,
  sdf_query_if.evaluator q
);

  // point held from the query until the next one
  vec3    held_point;
  vec3    cur_point;
  // cube results, one stage then aligned
  fp      cube_q;
  fp      cube_inf_q;
  fp      cube_pipe     [SDF_LATENCY-2];
  fp      cube_inf_pipe [SDF_LATENCY-2];
  fp      sponge_sdf;
  // strobe and scene travel together
  logic [SDF_LATENCY-1:0] vld_pipe;
  scene_t scene_pipe    [SDF_LATENCY];

  // new point goes straight in on the query cycle, held copy after
  assign cur_point = q.query_valid ? q.point : held_point;

  always_ff @(posedge clk_in) begin
    if (q.query_valid) begin
      held_point <= q.point;
    end
  end

  // plain cube, half size 0.5
  // repeated cube, cell centred on the origin
  always_ff @(posedge clk_in) begin
    cube_q     <= sd_box_fast(held_point, FP_HALF);
    cube_inf_q <= sd_box_fast(
        vec3_sub(vec3_fract(vec3_add(held_point, make_vec3(FP_HALF, FP_HALF, FP_HALF))),
                 make_vec3(FP_HALF, FP_HALF, FP_HALF)),
        FP_QUARTER);
    cube_pipe[0]     <= cube_q;
    cube_inf_pipe[0] <= cube_inf_q;
    for (int i = 1; i < SDF_LATENCY - 2; i++) begin
      cube_pipe[i]     <= cube_pipe[i-1];
      cube_inf_pipe[i] <= cube_inf_pipe[i-1];
    end
  end

  // sponge already four stages deep
  sdf_query_sponge_inf u_sponge (
    .clk_in (clk_in),
    .point  (cur_point),
    .sdf    (sponge_sdf)
  );

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe <= '0;
      for (int i = 0; i < SDF_LATENCY; i++) begin
        scene_pipe[i] <= scene_cube;
      end
    end else begin
      vld_pipe      <= {vld_pipe[SDF_LATENCY-2:0], q.query_valid};
      scene_pipe[0] <= q.scene;
      for (int i = 1; i < SDF_LATENCY; i++) begin
        scene_pipe[i] <= scene_pipe[i-1];
      end
    end
  end

  assign q.sdf_valid = vld_pipe[SDF_LATENCY-1];

  // pick by the scene that came with this query
  always_comb begin
    case (scene_pipe[SDF_LATENCY-1])
      scene_cube:     q.sdf = cube_pipe[SDF_LATENCY-3];
      scene_cube_inf: q.sdf = cube_inf_pipe[SDF_LATENCY-3];
      default:        q.sdf = sponge_sdf;
    endcase
  end

  a_latency: assert property (@(posedge clk_in) disable iff (!arst_n)
    q.query_valid |-> ##SDF_LATENCY q.sdf_valid)
    else $error("sdf_valid missing %0d cycles after query", SDF_LATENCY);

endmodule

//--- ray_marcher.sv
module ray_marcher import sdf_pkg::*; (
  input  logic   clk_in,
  input  logic   arst_n,
  input  logic   start,
  input  scene_t scene,
  input  vec3    origin,
  input  vec3    direction,
  output logic   busy,
  output logic   done,
  output logic   hit,
  output fp      distance,
  output step_t  steps,
  sdf_query_if.marcher q
);

  march_state_t state_q;
  // latched ray
  vec3          origin_q;
  vec3          dir_q;
  scene_t       scene_q;
  // answer from the evaluator, used in update
  fp            sdf_q;
  fp            t_next;
  logic         query_valid_q;
  logic         start_take;

  // start only counts from idle, and not on the done cycle itself
  assign start_take = start && (state_q == idle) && !done;

  // distance doubles as the t accumulator
  assign t_next = fp_add(distance, sdf_q);

  // sample point origin + t * dir
  assign q.point       = vec3_add(origin_q, vec3_scaled(dir_q, distance));
  assign q.scene       = scene_q;
  assign q.query_valid = query_valid_q;

  always_ff @(posedge clk_in) begin
    if (start_take) begin
      origin_q <= origin;
      dir_q    <= direction;
      scene_q  <= scene;
    end
    if (q.sdf_valid) begin
      sdf_q <= q.sdf;
    end
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state_q       <= idle;
      busy          <= 1'b0;
      done          <= 1'b0;
      hit           <= 1'b0;
      distance      <= '0;
      steps         <= '0;
      query_valid_q <= 1'b0;
    end else begin
      // single cycle strobes by default
      done          <= 1'b0;
      query_valid_q <= 1'b0;
      case (state_q)
        idle: begin
          if (start_take) begin
            state_q       <= issue;
            busy          <= 1'b1;
            hit           <= 1'b0;
            distance      <= '0;
            steps         <= '0;
            query_valid_q <= 1'b1;
          end
        end
        issue: begin
          // steps counts queries sent
          state_q <= wait_sdf;
          steps   <= steps + 6'd1;
        end
        wait_sdf: begin
          if (q.sdf_valid) begin
            state_q <= update;
          end
        end
        update: begin
          if (sdf_q < EPSILON) begin
            // surface reached, keep t of this sample
            hit     <= 1'b1;
            done    <= 1'b1;
            busy    <= 1'b0;
            state_q <= idle;
          end else if ((t_next > FAR_LIMIT) || (steps == MAX_STEPS)) begin
            // miss, past far plane or out of budget
            done    <= 1'b1;
            busy    <= 1'b0;
            state_q <= idle;
          end else begin
            distance      <= t_next;
            state_q       <= issue;
            query_valid_q <= 1'b1;
          end
        end
        default: begin
          state_q <= idle;
        end
      endcase
    end
  end

  // one query at a time, only from issue
  a_qv_issue: assert property (@(posedge clk_in) disable iff (!arst_n)
    q.query_valid |-> (state_q == issue))
    else $error("query_valid outside issue state");

  // accepted start shows up as busy next cycle, never with done
  a_start_busy: assert property (@(posedge clk_in) disable iff (!arst_n)
    start_take |=> (busy && !done))
    else $error("start accepted but busy/done wrong");

endmodule

//--- ray_march_top.sv
module ray_march_top import sdf_pkg::*; (
  input  logic   clk_in,
  input  logic   arst_n,
  input  logic   start,
  input  scene_t scene,
  input  vec3    origin,
  input  vec3    direction,
  output logic   busy,
  output logic   done,
  output logic   hit,
  output fp      distance,
  output step_t  steps
);

  // single query channel, marcher to evaluator
  sdf_query_if query_if ();

  ray_marcher u_marcher (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .start     (start),
    .scene     (scene),
    .origin    (origin),
    .direction (direction),
    .busy      (busy),
    .done      (done),
    .hit       (hit),
    .distance  (distance),
    .steps     (steps),
    .q         (query_if.marcher)
  );

  // fixed four cycle distance lookup
  sdf_scene_eval u_eval (
    .clk_in (clk_in),
    .arst_n (arst_n),
    .q      (query_if.evaluator)
  );

endmodule

//--- tb_ray_march.sv
module tb_ray_march import sdf_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int STEP_CYCLES  = SDF_LATENCY + 2;
  // cube hit, cube miss, 20 repeated cubes, 10 sponge rays
  localparam int N_RAYS       = 32;
  // idle cycles around each march
  localparam int RAY_GAP      = 4;
  localparam int MARCH_LIMIT  = int'(MAX_STEPS) * STEP_CYCLES + RAY_GAP;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_RAYS * MARCH_LIMIT + 20;
  localparam logic [31:0] SEED = 32'h33ceb40e;

  logic   clk_in;
  logic   arst_n;
  logic   start;
  scene_t scene;
  vec3    origin;
  vec3    direction;
  logic   busy;
  logic   done;
  logic   hit;
  fp      distance;
  step_t  steps;

  int errors = 0;
  int checks = 0;
  int cycle_count = 0;

  ray_march_top dut (
    .clk_in    (clk_in),
    .arst_n    (arst_n),
    .start     (start),
    .scene     (scene),
    .origin    (origin),
    .direction (direction),
    .busy      (busy),
    .done      (done),
    .hit       (hit),
    .distance  (distance),
    .steps     (steps)
  );

  always #2 clk_in = ~clk_in;

  // watchdog over the whole run
  always @(posedge clk_in) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic check_fp(input string name, input fp got, input fp exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_steps(input string name, input step_t got, input step_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // fold a point into a cell of size 2^log2_size, centred, absolute
  function automatic vec3 cell_fold(vec3 p, int log2_size);
    vec3 f;
    fp   h;
    if (log2_size >= 0) begin
      f = vec3_sl(vec3_fract(vec3_sr(p, log2_size)), log2_size);
      h = FP_HALF <<< log2_size;
    end else begin
      f = vec3_sr(vec3_fract(vec3_sl(p, -log2_size)), -log2_size);
      h = FP_HALF >>> -log2_size;
    end
    return vec3_abs(vec3_sub(f, make_vec3(h, h, h)));
  endfunction

  // union of four hole layers, deepest one wins
  function automatic fp sponge_distance(vec3 p);
    fp d;
    d = fp_add(cross_max_min(cell_fold(p, 1)), FP_MAGIC_A);
    d = fp_max(d, fp_add(cross_max_min(cell_fold(p, 0)), FP_MAGIC_B));
    d = fp_max(d, fp_add(cross_max_min(cell_fold(p, -1)), FP_MAGIC_C));
    d = fp_max(d, fp_add(cross_max_min(cell_fold(p, -3)), FP_MAGIC_D));
    return d;
  endfunction

  // gap from one coordinate to the nearest integer
  function automatic fp lattice_offset(fp c);
    fp f;
    f = fract(c);
    return fp_min(f, fp_sub(FP_ONE, f));
  endfunction

  function automatic fp scene_distance(scene_t sc, vec3 p);
    case (sc)
      scene_cube:     return sd_box_fast(p, FP_HALF);
      // quarter cube on every integer lattice point
      scene_cube_inf: return fp_sub(fp_max(fp_max(lattice_offset(vec3_x(p)),
                                                   lattice_offset(vec3_y(p))),
                                            lattice_offset(vec3_z(p))),
                                     FP_QUARTER);
      default:        return sponge_distance(p);
    endcase
  endfunction

  // step rule: sample, stop on hit or miss, else advance t
  task automatic march_model(input scene_t sc, input vec3 org, input vec3 dir,
                             output logic exp_hit, output fp exp_t, output step_t exp_steps);
    fp    t;
    fp    d;
    int   n;
    logic fin;
    t   = '0;
    n   = 0;
    fin = 1'b0;
    exp_hit = 1'b0;
    while (!fin) begin
      d = scene_distance(sc, vec3_add(org, vec3_scaled(dir, t)));
      n++;
      if (d < EPSILON) begin
        exp_hit = 1'b1;
        fin     = 1'b1;
      end else if ((fp_add(t, d) > FAR_LIMIT) || (n == int'(MAX_STEPS))) begin
        fin = 1'b1;
      end else begin
        t = fp_add(t, d);
      end
    end
    exp_t     = t;
    exp_steps = step_t'(n);
  endtask

  // one march from start to done, optional stray start mid flight
  task automatic run_march(input string label, input scene_t sc, input vec3 org,
                           input vec3 dir, input logic stray_start);
    int    cycles;
    logic  exp_hit;
    fp     exp_t;
    step_t exp_steps;
    march_model(sc, org, dir, exp_hit, exp_t, exp_steps);
    @(negedge clk_in);
    start     = 1'b1;
    scene     = sc;
    origin    = org;
    direction = dir;
    cycles    = 0;
    do begin
      @(negedge clk_in);
      cycles++;
      if (cycles == 1) begin
        check_bit({label, " busy after start"}, busy, 1'b1);
      end
      start = stray_start && (cycles == 3);
      if (start) begin
        // different ray, must not be latched
        scene     = scene_sponge_inf;
        origin    = make_vec3(FP_ONE, -FP_ONE, FP_HALF);
        direction = make_vec3(FP_ONE, 16'sd0, 16'sd0);
      end
    end while (!done && cycles < MARCH_LIMIT);
    if (!done) begin
      errors++;
      $display("%s: march did not finish, no done after %0d cycles", label, cycles);
    end else begin
      check_bit({label, " busy at done"}, busy, 1'b0);
      check_bit({label, " hit"}, hit, exp_hit);
      check_fp({label, " distance"}, distance, exp_t);
      check_steps({label, " steps"}, steps, exp_steps);
      check_cycles({label, " start to done cycles"}, cycles,
                   int'(exp_steps) * STEP_CYCLES + 1);
    end
  endtask

  function automatic fp pick_coord();
    int r;
    // about -4.0 to +4.0
    r = int'($urandom % 32'd2048) - 1024;
    return fp'(r);
  endfunction

  function automatic vec3 axis_direction();
    int axis;
    fp  s;
    axis = int'($urandom % 32'd3);
    s    = ($urandom % 32'd2) != 0 ? FP_ONE : -FP_ONE;
    case (axis)
      0:       return make_vec3(s, 16'sd0, 16'sd0);
      1:       return make_vec3(16'sd0, s, 16'sd0);
      default: return make_vec3(16'sd0, 16'sd0, s);
    endcase
  endfunction

  task automatic test_reset_state();
    check_bit("busy after reset", busy, 1'b0);
    check_bit("done after reset", done, 1'b0);
    check_bit("hit after reset", hit, 1'b0);
    check_fp("distance after reset", distance, 16'sd0);
    check_steps("steps after reset", steps, 6'd0);
  endtask

  task automatic test_cube_hit();
    run_march("cube hit", scene_cube, make_vec3(16'sd0, 16'sd0, -16'sd768),
              make_vec3(16'sd0, 16'sd0, FP_ONE), 1'b1);
    // face at z = -0.5, reached after one 2.5 step
    check_fp("cube hit distance 2.5", distance, 16'sd640);
    check_steps("cube hit step count", steps, 6'd2);
  endtask

  task automatic test_cube_miss();
    run_march("cube miss", scene_cube, make_vec3(16'sd768, 16'sd0, -16'sd768),
              make_vec3(16'sd0, 16'sd0, FP_ONE), 1'b0);
    check_bit("cube miss hit", hit, 1'b0);
  endtask

  task automatic test_cube_inf();
    for (int i = 0; i < 20; i++) begin
      run_march($sformatf("cube_inf ray %0d", i), scene_cube_inf,
                make_vec3(pick_coord(), pick_coord(), pick_coord()), axis_direction(), 1'b0);
    end
  endtask

  task automatic test_sponge_inf();
    vec3 dir;
    for (int i = 0; i < 10; i++) begin
      dir = ($urandom % 32'd2) != 0 ? make_vec3(16'sd0, 16'sd0, FP_ONE)
                                    : make_vec3(FP_ONE, 16'sd0, 16'sd0);
      run_march($sformatf("sponge ray %0d", i), scene_sponge_inf,
                make_vec3(pick_coord(), pick_coord(), pick_coord()), dir, 1'b0);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    clk_in    = 1'b0;
    arst_n    = 1'b0;
    start     = 1'b0;
    scene     = scene_cube;
    origin    = '0;
    direction = '0;
    repeat (RESET_CYCLES) @(negedge clk_in);
    arst_n = 1'b1;
    @(negedge clk_in);
    test_reset_state();
    test_cube_hit();
    test_cube_miss();
    test_cube_inf();
    test_sponge_inf();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
sdf_pkg.sv
sdf_query_if.sv
sdf_query_sponge_inf.sv
sdf_scene_eval.sv
ray_marcher.sv
ray_march_top.sv
tb_ray_march.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_ray_march
RTL_TOP   ?= ray_march_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# pass only if the pass message shows up as a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
